/* all.f */
+incdir+hdl
hdl/lv_pkg.sv
hdl/lv_fault_filter.sv
hdl/lv_efuse_loader.sv
hdl/lv_state_timer.sv
hdl/lv_fsm_ctrl.sv
hdl/lv_ctrl_top.sv
dv/tb_lv_ctrl.sv

/* dv/tb_lv_ctrl.sv */
/*
 * Testbench for the LV side controller
 * Applies a table of input settings, answers the eFuse handshake after a
 * random delay and checks state, enables, interrupt, trim and latched flags.
 */
`timescale 1ns/1ns
`include "lv_defs.svh"

module tb_lv_ctrl;

    import lv_pkg::*;

    // control column {pwr_on, fsenb_n, test_mode, efuse_done}
    localparam logic [3:0] C_OFF = 4'b0100;
    localparam logic [3:0] C_ON  = 4'b1100;
    localparam logic [3:0] C_FSL = 4'b1000;
    localparam logic [3:0] C_EDN = 4'b1101;
    // register column {nml_en, cfg_en, bist_en, rst_en}
    localparam logic [3:0] R_NONE = 4'b0000;
    localparam logic [3:0] R_NML  = 4'b1000;
    localparam logic [3:0] R_CFG  = 4'b0100;
    localparam logic [3:0] R_BIST = 4'b0010;
    localparam logic [3:0] R_RST  = 4'b0001;
    localparam logic [`LV_EFUSE_W-1:0] W_BAD  = 16'h3C12;
    localparam logic [`LV_EFUSE_W-1:0] W_GOOD = 16'hA512;
    localparam logic [`LV_EFUSE_W-1:0] W_NEW  = 16'hA55A;
    localparam logic [`LV_FLT_N-1:0] M_NONE  = '0;
    localparam logic [`LV_FLT_N-1:0] M_OC    = `LV_FLT_N'(1) << FLT_OC;
    localparam logic [`LV_FLT_N-1:0] M_OC_OT = M_OC | (`LV_FLT_N'(1) << FLT_OT);
    localparam logic [`LV_FLT_N-1:0] M_SCP   = `LV_FLT_N'(1) << FLT_SCP;

    logic                   i_clk;
    logic                   i_rst_n;
    logic [`LV_FLT_N-1:0]   i_flt_raw;
    logic                   i_pwr_on;
    logic                   i_test_mode;
    logic                   i_fsenb_n;
    logic                   i_efuse_done;
    logic                   i_reg_nml_en;
    logic                   i_reg_cfg_en;
    logic                   i_reg_bist_en;
    logic                   i_reg_rst_en;
    logic                   i_efuse_ack;
    logic [`LV_EFUSE_W-1:0] i_efuse_data;
    logic                   o_pwm_en;
    logic                   o_wdg_scan_en;
    logic                   o_wdg_owt_en;
    logic                   o_spi_en;
    logic                   o_fsc_en;
    logic                   o_owt_com_en;
    logic                   o_cfg_crc_reg_en;
    logic                   o_bist_en;
    logic                   o_intb_n;
    lv_state_e              o_lv_state;
    logic                   o_efuse_req;
    logic [`LV_EFUSE_W-1:0] o_trim;
    logic [`LV_FLT_N-1:0]   o_flt_sticky;
    logic [8:0]             act_out;

    // stimulus table, one entry per row
    string                  row_name [$];
    logic [3:0]             row_ctl [$];
    logic [3:0]             row_reg [$];
    logic [`LV_FLT_N-1:0]   row_flt [$];
    logic [`LV_EFUSE_W-1:0] row_word [$];
    int                     row_wait [$];
    lv_state_e              row_state [$];
    logic [`LV_FLT_N-1:0]   row_sticky [$];

    logic [`LV_EFUSE_W-1:0] cur_word;
    integer                 seed = 32'hc081_76ed;
    int                     err_cnt = 0;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 200;

    lv_ctrl_top uut (.*);

    assign act_out = {o_pwm_en, o_wdg_scan_en, o_wdg_owt_en, o_spi_en, o_fsc_en,
                      o_owt_com_en, o_cfg_crc_reg_en, o_bist_en, o_intb_n};

    // ==================================================
    // expected enables per state
    // ==================================================
    // {pwm, wdg_scan, wdg_owt, spi, fsc, owt_com, cfg_crc_reg, bist, intb_n}
    function automatic logic [8:0] exp_outputs(lv_state_e st);
        case (st)
            NML:      return 9'b111111001;
            WAIT:     return 9'b000101000;
            TEST:     return 9'b000101101;
            CFG:      return 9'b001101101;
            FAILSAFE: return 9'b001111000;
            FAULT:    return 9'b000101000;
            BIST:     return 9'b000100011;
            RST:      return 9'b000000001;
            default:  return 9'b000000000;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAIL %s: expected %0h, actual %0h", what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic add_row(input string n, input logic [3:0] c, input logic [3:0] r,
                           input logic [`LV_FLT_N-1:0] f, input logic [`LV_EFUSE_W-1:0] w,
                           input int wt, input lv_state_e s, input logic [`LV_FLT_N-1:0] k);
        row_name.push_back(n);
        row_ctl.push_back(c);
        row_reg.push_back(r);
        row_flt.push_back(f);
        row_word.push_back(w);
        row_wait.push_back(wt);
        row_state.push_back(s);
        row_sticky.push_back(k);
        cycle_limit += wt;
    endtask

    task automatic build_table();
        add_row("pwr_off", C_OFF, R_NONE, M_NONE, W_BAD, 3, PWR_DWN, M_NONE);
        add_row("bad_word", C_ON, R_NONE, M_NONE, W_BAD, 20, TEST, M_NONE);
        add_row("efuse_done", C_EDN, R_NONE, M_NONE, W_GOOD, 2, WAIT, M_NONE);
        add_row("good_word", C_ON, R_NONE, M_NONE, W_GOOD, 20, CFG, M_NONE);
        add_row("cfg_to_nml", C_ON, R_NML, M_NONE, W_GOOD, 2, NML, M_NONE);
        add_row("recov_short", C_ON, R_NONE, M_OC, W_GOOD, `LV_FLT_DEB - 1, NML, M_NONE);
        add_row("recov_gap", C_ON, R_NONE, M_NONE, W_GOOD, 3, NML, M_NONE);
        add_row("recov_latch", C_ON, R_NONE, M_OC, W_GOOD, `LV_FLT_DEB + 1, FAILSAFE, M_OC);
        add_row("recov_sticky", C_ON, R_NONE, M_NONE, W_GOOD, 20, FAILSAFE, M_OC);
        add_row("severe_fs", C_ON, R_NONE, M_OC_OT, W_GOOD, `LV_FLT_DEB + 1, FAULT, M_OC_OT);
        add_row("fault_hold", C_ON, R_NONE, M_NONE, W_GOOD, 5, FAULT, M_OC_OT);
        add_row("fault_rst", C_ON, R_RST, M_NONE, W_NEW, 1, RST, M_OC_OT);
        add_row("rst_pulse", C_ON, R_NONE, M_NONE, W_NEW, `LV_RST_CYC - 1, RST, M_NONE);
        add_row("rst_done", C_ON, R_NONE, M_NONE, W_NEW, 1, WAIT, M_NONE);
        add_row("reload", C_ON, R_NONE, M_NONE, W_NEW, 20, CFG, M_NONE);
        add_row("nml_again", C_ON, R_NML, M_NONE, W_NEW, 2, NML, M_NONE);
        add_row("fsenb_low", C_FSL, R_NONE, M_NONE, W_NEW, 2, FAILSAFE, M_NONE);
        add_row("dwell_hold", C_ON, R_NONE, M_NONE, W_NEW, `LV_FS_DWELL - 2, FAILSAFE, M_NONE);
        add_row("dwell_done", C_ON, R_NONE, M_NONE, W_NEW, 1, NML, M_NONE);
        add_row("nml_to_cfg", C_ON, R_CFG, M_NONE, W_NEW, 2, CFG, M_NONE);
        add_row("bist_enter", C_ON, R_BIST, M_NONE, W_NEW, 1, BIST, M_NONE);
        add_row("bist_run", C_ON, R_NONE, M_NONE, W_NEW, `LV_BIST_CYC - 1, BIST, M_NONE);
        add_row("bist_done", C_ON, R_NONE, M_NONE, W_NEW, 1, CFG, M_NONE);
        add_row("nml_third", C_ON, R_NML, M_NONE, W_NEW, 2, NML, M_NONE);
        add_row("severe_nml", C_ON, R_NONE, M_SCP, W_NEW, `LV_FLT_DEB + 1, FAULT, M_SCP);
        add_row("pwr_loss", C_OFF, R_NONE, M_NONE, W_NEW, 2, PWR_DWN, M_SCP);
    endtask

    // ==================================================
    // clock, eFuse responder, cycle limit
    // ==================================================
    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ack 1 to 4 cycles after req rises, release 1 to 4 cycles after req falls
    always @(negedge i_clk) begin : efuse_resp
        int unsigned delay;
        if (o_efuse_req && !i_efuse_ack) begin
            delay = ($unsigned($random(seed)) % 4) + 1;
            repeat (delay - 1) @(negedge i_clk);
            i_efuse_data = cur_word;
            i_efuse_ack  = 1'b1;
        end else if (!o_efuse_req && i_efuse_ack) begin
            delay = ($unsigned($random(seed)) % 4) + 1;
            repeat (delay - 1) @(negedge i_clk);
            i_efuse_ack = 1'b0;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main_seq
        int errs_before;
        int pass_rows;
        int fail_rows;
        pass_rows     = 0;
        fail_rows     = 0;
        i_rst_n       = 1'b0;
        i_flt_raw     = '0;
        i_pwr_on      = 1'b0;
        i_test_mode   = 1'b0;
        i_fsenb_n     = 1'b1;
        i_efuse_done  = 1'b0;
        i_reg_nml_en  = 1'b0;
        i_reg_cfg_en  = 1'b0;
        i_reg_bist_en = 1'b0;
        i_reg_rst_en  = 1'b0;
        i_efuse_ack   = 1'b0;
        i_efuse_data  = '0;
        cur_word      = '0;
        build_table();
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        check("reset state", PWR_DWN, o_lv_state);
        check("reset outputs", 9'b000000001, act_out);
        check("reset efuse_req", 1'b0, o_efuse_req);
        if (err_cnt == 0) begin
            $display("reset checks passed");
            pass_rows++;
        end else begin
            $display("reset checks failed");
            fail_rows++;
        end
        i_rst_n = 1'b1;
        for (int i = 0; i < row_name.size(); i++) begin
            errs_before = err_cnt;
            {i_pwr_on, i_fsenb_n, i_test_mode, i_efuse_done} = row_ctl[i];
            {i_reg_nml_en, i_reg_cfg_en, i_reg_bist_en, i_reg_rst_en} = row_reg[i];
            i_flt_raw = row_flt[i];
            cur_word  = row_word[i];
            repeat (row_wait[i]) @(negedge i_clk);
            check({row_name[i], " state"}, row_state[i], o_lv_state);
            check({row_name[i], " enables"}, exp_outputs(row_state[i]), act_out);
            check({row_name[i], " sticky"}, row_sticky[i], o_flt_sticky);
            // trim is settled once a load has ended in TEST or CFG
            if (row_state[i] == TEST || row_state[i] == CFG) begin
                check({row_name[i], " trim"}, row_word[i], o_trim);
            end
            if (err_cnt == errs_before) begin
                $display("row %0d %s passed", i, row_name[i]);
                pass_rows++;
            end else begin
                $display("row %0d %s failed", i, row_name[i]);
                fail_rows++;
            end
        end
        $display("tests passed %0d, tests failed %0d, errors %0d", pass_rows, fail_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* hdl/lv_ctrl_top.sv */
/*
 * LV side controller top level
 * Error filter, eFuse loader, state timer and operating-mode FSM.
 */
`timescale 1ns/1ns
`include "lv_defs.svh"

module lv_ctrl_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`LV_FLT_N-1:0]   i_flt_raw,
    input  logic                   i_pwr_on,
    input  logic                   i_test_mode,
    input  logic                   i_fsenb_n,
    input  logic                   i_efuse_done,
    input  logic                   i_reg_nml_en,
    input  logic                   i_reg_cfg_en,
    input  logic                   i_reg_bist_en,
    input  logic                   i_reg_rst_en,
    input  logic                   i_efuse_ack,
    input  logic [`LV_EFUSE_W-1:0] i_efuse_data,
    output logic                   o_pwm_en,
    output logic                   o_wdg_scan_en,
    output logic                   o_wdg_owt_en,
    output logic                   o_spi_en,
    output logic                   o_fsc_en,
    output logic                   o_owt_com_en,
    output logic                   o_cfg_crc_reg_en,
    output logic                   o_bist_en,
    output logic                   o_intb_n,
    output lv_pkg::lv_state_e      o_lv_state,
    output logic                   o_efuse_req,
    output logic [`LV_EFUSE_W-1:0] o_trim,
    output logic [`LV_FLT_N-1:0]   o_flt_sticky
);

    logic flt_severe;
    logic flt_recov;
    logic flt_clr;
    logic load_start;
    logic load_done;
    logic load_vld;
    logic tmr_expired;

    lv_fault_filter u_fault_filter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_flt_raw    (i_flt_raw),
        .i_flt_clr    (flt_clr),
        .o_flt_sticky (o_flt_sticky),
        .o_flt_severe (flt_severe),
        .o_flt_recov  (flt_recov)
    );

    lv_efuse_loader u_efuse_loader (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_load_start (load_start),
        .o_efuse_req  (o_efuse_req),
        .i_efuse_ack  (i_efuse_ack),
        .i_efuse_data (i_efuse_data),
        .o_trim       (o_trim),
        .o_load_done  (load_done),
        .o_load_vld   (load_vld)
    );

    // timer follows the registered state
    lv_state_timer u_state_timer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_state   (o_lv_state),
        .o_expired (tmr_expired)
    );

    lv_fsm_ctrl u_fsm_ctrl (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_pwr_on         (i_pwr_on),
        .i_test_mode      (i_test_mode),
        .i_efuse_done     (i_efuse_done),
        .i_fsenb_n        (i_fsenb_n),
        .i_flt_severe     (flt_severe),
        .i_flt_recov      (flt_recov),
        .i_load_done      (load_done),
        .i_load_vld       (load_vld),
        .i_tmr_expired    (tmr_expired),
        .i_reg_nml_en     (i_reg_nml_en),
        .i_reg_cfg_en     (i_reg_cfg_en),
        .i_reg_bist_en    (i_reg_bist_en),
        .i_reg_rst_en     (i_reg_rst_en),
        .o_state          (o_lv_state),
        .o_load_start     (load_start),
        .o_flt_clr        (flt_clr),
        .o_pwm_en         (o_pwm_en),
        .o_wdg_scan_en    (o_wdg_scan_en),
        .o_wdg_owt_en     (o_wdg_owt_en),
        .o_spi_en         (o_spi_en),
        .o_fsc_en         (o_fsc_en),
        .o_owt_com_en     (o_owt_com_en),
        .o_cfg_crc_reg_en (o_cfg_crc_reg_en),
        .o_bist_en        (o_bist_en),
        .o_intb_n         (o_intb_n)
    );

endmodule

/* hdl/lv_defs.svh */
/*
 * LV controller shared constants
 * Widths, debounce length, state timer lengths and the eFuse validity magic.
 */
`ifndef LV_DEFS_SVH
`define LV_DEFS_SVH

// ==================================================
// widths
// ==================================================
`define LV_ST_W        4
`define LV_FLT_N       14
`define LV_TMR_W       5
`define LV_EFUSE_W     16

// ==================================================
// timing
// ==================================================
// consecutive high cycles before a raw flag counts
`define LV_FLT_DEB     3
// fixed lengths of the timed states, in clock cycles
`define LV_RST_CYC     8
`define LV_BIST_CYC    16
`define LV_FS_DWELL    12

// upper byte of a programmed trim word
`define LV_EFUSE_MAGIC 8'hA5

`endif

/* hdl/lv_efuse_loader.sv */
/*
 * eFuse trim loader
 * Reads one word from the fuse macro over a four-phase req/ack handshake,
 * holds it as the trim word and flags whether it carries the valid magic.
 */
`timescale 1ns/1ns
`include "lv_defs.svh"

module lv_efuse_loader (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_load_start,
    output logic                   o_efuse_req,
    input  logic                   i_efuse_ack,
    input  logic [`LV_EFUSE_W-1:0] i_efuse_data,
    output logic [`LV_EFUSE_W-1:0] o_trim,
    output logic                   o_load_done,
    output logic                   o_load_vld
);

    localparam logic [1:0] LD_IDLE    = 2'd0;
    localparam logic [1:0] LD_REQ     = 2'd1;
    localparam logic [1:0] LD_RELEASE = 2'd2;
    localparam logic [1:0] LD_DONE    = 2'd3;

    logic [1:0] ld_st;
    logic [1:0] ld_nxt;
    logic       done_flag;

    // ==================================================
    // handshake sequencer
    // ==================================================
    always_comb begin
        ld_nxt = ld_st;
        case (ld_st)
            // no new request while the macro still holds ack
            LD_IDLE:    if (i_load_start && !done_flag && !i_efuse_ack) ld_nxt = LD_REQ;
            LD_REQ:     if (i_efuse_ack) ld_nxt = LD_RELEASE;
            LD_RELEASE: if (!i_efuse_ack) ld_nxt = LD_DONE;
            default:    ld_nxt = LD_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ld_st       <= LD_IDLE;
            o_efuse_req <= 1'b0;
        end else begin
            ld_st       <= ld_nxt;
            o_efuse_req <= (ld_nxt == LD_REQ);
        end
    end

    // one load per start request
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_flag <= 1'b0;
        end else if (!i_load_start) begin
            done_flag <= 1'b0;
        end else if (ld_st == LD_DONE) begin
            done_flag <= 1'b1;
        end
    end

    // ==================================================
    // trim capture
    // ==================================================
    // data is stable while ack is high
    always_ff @(posedge i_clk) begin
        if (ld_st == LD_REQ && i_efuse_ack) begin
            o_trim <= i_efuse_data;
        end
    end

    assign o_load_done = (ld_st == LD_DONE);
    assign o_load_vld  = (o_trim[`LV_EFUSE_W-1 -: 8] == `LV_EFUSE_MAGIC);

endmodule

/* hdl/lv_fault_filter.sv */
/*
 * Error flag filter
 * Debounces each raw LV/HV error flag, latches it until cleared and
 * reduces the latched flags to a severe and a recoverable group level.
 */
`timescale 1ns/1ns
`include "lv_defs.svh"

module lv_fault_filter (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [`LV_FLT_N-1:0] i_flt_raw,
    input  logic                 i_flt_clr,
    output logic [`LV_FLT_N-1:0] o_flt_sticky,
    output logic                 o_flt_severe,
    output logic                 o_flt_recov
);

    import lv_pkg::*;

    localparam int CNT_W = $clog2(`LV_FLT_DEB + 1);
    localparam logic [CNT_W-1:0] DEB_MAX = CNT_W'(`LV_FLT_DEB);

    logic [CNT_W-1:0]     run_cnt [`LV_FLT_N];
    logic [`LV_FLT_N-1:0] deb_hit;

    // ==================================================
    // debounce
    // ==================================================
    // hit on the LV_FLT_DEB-th consecutive high cycle
    always_comb begin
        for (int i = 0; i < `LV_FLT_N; i++) begin
            deb_hit[i] = i_flt_raw[i] && (run_cnt[i] >= DEB_MAX - 1'b1);
        end
    end

    // run length of each flag, restarts when the flag drops
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LV_FLT_N; i++) begin
                run_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `LV_FLT_N; i++) begin
                if (!i_flt_raw[i]) begin
                    run_cnt[i] <= '0;
                end else if (run_cnt[i] != DEB_MAX) begin
                    run_cnt[i] <= run_cnt[i] + 1'b1;
                end
            end
        end
    end

    // ==================================================
    // sticky latch and grouping
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_flt_sticky <= '0;
        end else if (i_flt_clr) begin
            o_flt_sticky <= '0;
        end else begin
            o_flt_sticky <= o_flt_sticky | deb_hit;
        end
    end

    assign o_flt_recov  = |o_flt_sticky[FLT_SCAN_CRC:FLT_DT];
    assign o_flt_severe = |o_flt_sticky[FLT_SCP:FLT_MM];

endmodule

/* hdl/lv_fsm_ctrl.sv */
/*
 * Operating-mode controller
 * Power-up, trim load, test, config, normal, failsafe, fault, reset and
 * BIST sequencing, with registered block enables and the interrupt line.
 */
`timescale 1ns/1ns

module lv_fsm_ctrl (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_pwr_on,
    input  logic              i_test_mode,
    input  logic              i_efuse_done,
    input  logic              i_fsenb_n,
    input  logic              i_flt_severe,
    input  logic              i_flt_recov,
    input  logic              i_load_done,
    input  logic              i_load_vld,
    input  logic              i_tmr_expired,
    input  logic              i_reg_nml_en,
    input  logic              i_reg_cfg_en,
    input  logic              i_reg_bist_en,
    input  logic              i_reg_rst_en,
    output lv_pkg::lv_state_e o_state,
    output logic              o_load_start,
    output logic              o_flt_clr,
    output logic              o_pwm_en,
    output logic              o_wdg_scan_en,
    output logic              o_wdg_owt_en,
    output logic              o_spi_en,
    output logic              o_fsc_en,
    output logic              o_owt_com_en,
    output logic              o_cfg_crc_reg_en,
    output logic              o_bist_en,
    output logic              o_intb_n
);

    import lv_pkg::*;

    lv_state_e state_nxt;
    logic      pwm_d;
    logic      wdg_scan_d;
    logic      wdg_owt_d;
    logic      spi_d;
    logic      fsc_d;
    logic      owt_com_d;
    logic      cfg_crc_reg_d;
    logic      bist_d;
    logic      intb_n_d;

    // ==================================================
    // next-state logic
    // ==================================================
    always_comb begin
        state_nxt = o_state;
        if (!i_pwr_on) begin
            // supply loss wins from every mode
            state_nxt = PWR_DWN;
        end else begin
            case (o_state)
                PWR_DWN: state_nxt = WAIT;
                WAIT: begin
                    if (i_test_mode || (i_load_done && !i_load_vld)) begin
                        state_nxt = TEST;
                    end else if (i_load_done) begin
                        state_nxt = CFG;
                    end
                end
                TEST: if (i_efuse_done) state_nxt = WAIT;
                CFG: begin
                    if (i_reg_nml_en) begin
                        state_nxt = NML;
                    end else if (i_reg_bist_en) begin
                        state_nxt = BIST;
                    end
                end
                NML: begin
                    if (i_flt_severe) begin
                        state_nxt = FAULT;
                    end else if (i_flt_recov || !i_fsenb_n) begin
                        state_nxt = FAILSAFE;
                    end else if (i_reg_rst_en) begin
                        state_nxt = RST;
                    end else if (i_reg_cfg_en) begin
                        state_nxt = CFG;
                    end
                end
                FAILSAFE: begin
                    if (i_flt_severe) begin
                        state_nxt = FAULT;
                    end else if (i_tmr_expired && !i_flt_recov && i_fsenb_n) begin
                        state_nxt = NML;
                    end
                end
                FAULT: if (i_reg_rst_en) state_nxt = RST;
                RST:   if (i_tmr_expired) state_nxt = WAIT;
                BIST:  if (i_tmr_expired) state_nxt = CFG;
                default: state_nxt = PWR_DWN;
            endcase
        end
    end

    // ==================================================
    // enable decode from the next state
    // ==================================================
    always_comb begin
        pwm_d         = 1'b0;
        wdg_scan_d    = 1'b0;
        wdg_owt_d     = 1'b0;
        spi_d         = 1'b0;
        fsc_d         = 1'b0;
        owt_com_d     = 1'b0;
        cfg_crc_reg_d = 1'b0;
        bist_d        = 1'b0;
        case (state_nxt)
            NML: begin
                pwm_d      = 1'b1;
                wdg_scan_d = 1'b1;
                wdg_owt_d  = 1'b1;
                spi_d      = 1'b1;
                owt_com_d  = 1'b1;
                fsc_d      = 1'b1;
            end
            WAIT, FAULT: begin
                spi_d     = 1'b1;
                owt_com_d = 1'b1;
            end
            TEST, CFG: begin
                spi_d         = 1'b1;
                owt_com_d     = 1'b1;
                cfg_crc_reg_d = 1'b1;
                // watchdog on the one-wire link runs in config only
                wdg_owt_d     = (state_nxt == CFG);
            end
            FAILSAFE: begin
                fsc_d     = 1'b1;
                spi_d     = 1'b1;
                owt_com_d = 1'b1;
                wdg_owt_d = 1'b1;
            end
            BIST: begin
                bist_d = 1'b1;
                spi_d  = 1'b1;
            end
            default: ;
        endcase
        intb_n_d = !(state_nxt inside {PWR_DWN, WAIT, FAILSAFE, FAULT});
    end

    // state and outputs change on the same edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state          <= PWR_DWN;
            o_pwm_en         <= 1'b0;
            o_wdg_scan_en    <= 1'b0;
            o_wdg_owt_en     <= 1'b0;
            o_spi_en         <= 1'b0;
            o_fsc_en         <= 1'b0;
            o_owt_com_en     <= 1'b0;
            o_cfg_crc_reg_en <= 1'b0;
            o_bist_en        <= 1'b0;
            o_intb_n         <= 1'b1;
        end else begin
            o_state          <= state_nxt;
            o_pwm_en         <= pwm_d;
            o_wdg_scan_en    <= wdg_scan_d;
            o_wdg_owt_en     <= wdg_owt_d;
            o_spi_en         <= spi_d;
            o_fsc_en         <= fsc_d;
            o_owt_com_en     <= owt_com_d;
            o_cfg_crc_reg_en <= cfg_crc_reg_d;
            o_bist_en        <= bist_d;
            o_intb_n         <= intb_n_d;
        end
    end

    assign o_load_start = (o_state == WAIT);
    assign o_flt_clr    = (o_state == RST);

endmodule

/* hdl/lv_pkg.sv */
/*
 * LV controller package
 * Operating-mode state codes and raw error flag bit positions.
 */
`include "lv_defs.svh"

package lv_pkg;

    // operating modes, codes fixed by the register map
    typedef enum logic [`LV_ST_W-1:0] {
        PWR_DWN  = 4'd0,
        WAIT     = 4'd1,
        TEST     = 4'd2,
        NML      = 4'd3,
        FAILSAFE = 4'd4,
        FAULT    = 4'd5,
        CFG      = 4'd6,
        RST      = 4'd7,
        BIST     = 4'd8
    } lv_state_e;

    // raw error vector layout, recoverable group in the low bits
    typedef enum logic [$clog2(`LV_FLT_N)-1:0] {
        FLT_DT       = 4'd0,
        FLT_OC       = 4'd1,
        FLT_OWT_COM  = 4'd2,
        FLT_WDG_TMO  = 4'd3,
        FLT_SPI      = 4'd4,
        FLT_SCAN_CRC = 4'd5,
        FLT_MM       = 4'd6,
        FLT_VSUP_UV  = 4'd7,
        FLT_VSUP_OV  = 4'd8,
        FLT_VCC_UV   = 4'd9,
        FLT_VCC_OV   = 4'd10,
        FLT_OT       = 4'd11,
        FLT_DESAT    = 4'd12,
        FLT_SCP      = 4'd13
    } lv_flt_idx_e;

endpackage

/* hdl/lv_state_timer.sv */
/*
 * State dwell timer
 * Counts cycles spent in the current operating mode and flags expiry of
 * the reset pulse, the BIST run and the failsafe minimum dwell.
 */
`timescale 1ns/1ns
`include "lv_defs.svh"

module lv_state_timer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  lv_pkg::lv_state_e i_state,
    output logic              o_expired
);

    import lv_pkg::*;

    lv_state_e             prev_state;
    logic [`LV_TMR_W-1:0]  tmr_q;
    logic [`LV_TMR_W-1:0]  tmr_cur;

    // count restarts on the first cycle of a new state
    assign tmr_cur = (i_state != prev_state) ? '0 : tmr_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prev_state <= PWR_DWN;
            tmr_q      <= '0;
        end else begin
            prev_state <= i_state;
            if (tmr_cur != '1) begin
                tmr_q <= tmr_cur + 1'b1;
            end else begin
                tmr_q <= tmr_cur;
            end
        end
    end

    // failsafe stays expired once the dwell has passed
    always_comb begin
        case (i_state)
            RST:      o_expired = (tmr_cur >= `LV_TMR_W'(`LV_RST_CYC - 1));
            BIST:     o_expired = (tmr_cur >= `LV_TMR_W'(`LV_BIST_CYC - 1));
            FAILSAFE: o_expired = (tmr_cur >= `LV_TMR_W'(`LV_FS_DWELL - 1));
            default:  o_expired = 1'b0;
        endcase
    end

endmodule
